/* hdl/sonar_pkg.sv */
package sonar_pkg;

  // energy window and measurement range
  localparam int WINDOW_LEN = 8;   // samples per energy window
  localparam int MAX_DELAY = 255;  // give up after this many analysed steps
  localparam int DELAY_W = 8;
  localparam int SUM_W = 16;       // holds WINDOW_LEN * 128

  localparam int WIN_CNT_W = $clog2(WINDOW_LEN);
  localparam logic [WIN_CNT_W-1:0] WIN_LAST = WIN_CNT_W'(WINDOW_LEN - 1);
  localparam logic [DELAY_W-1:0] DELAY_MAX = DELAY_W'(MAX_DELAY);

  // speaker burst
  localparam int BURST_STEPS = 4;
  localparam int BURST_AMP = 16000;  // magnitude on the signed 16-bit output
  localparam int AMP_W = 16;

  localparam int BURST_CNT_W = $clog2(BURST_STEPS + 1);
  localparam logic [BURST_CNT_W-1:0] BURST_CNT_END = BURST_CNT_W'(BURST_STEPS);

  localparam logic signed [AMP_W-1:0] AMP_POS = AMP_W'(BURST_AMP);
  localparam logic signed [AMP_W-1:0] AMP_NEG = AMP_W'(-BURST_AMP);

  // controller states
  // BURST waits for the speaker burst to finish, RELEASE for result_ack low
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    BURST   = 3'd1,
    LISTEN  = 3'd2,
    REPORT  = 3'd3,
    RELEASE = 3'd4
  } range_state_t;

endpackage

/* hdl/impulse_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module impulse_generator (
  input  wire                                     clk_in,
  input  wire                                     rst_in,
  input  wire                                     step,
  input  wire                                     burst_start,
  output logic                                    burst_active,
  output logic                                    speaker_on,
  output logic signed [sonar_pkg::AMP_W-1:0]      amp
);

  logic                                armed;   // waiting for or inside a burst
  logic                                active;
  logic [sonar_pkg::BURST_CNT_W-1:0]   cnt;     // burst samples emitted so far

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      armed  <= 1'b0;
      active <= 1'b0;
      cnt    <= '0;
      amp    <= '0;
    end else begin
      if (burst_start) begin
        armed <= 1'b1;
        cnt   <= '0;
      end else if (armed && step) begin
        if (cnt == sonar_pkg::BURST_CNT_END) begin
          // last sample has been on the speaker for a full step
          armed  <= 1'b0;
          active <= 1'b0;
          amp    <= '0;
        end else begin
          active <= 1'b1;
          amp    <= cnt[0] ? sonar_pkg::AMP_NEG : sonar_pkg::AMP_POS;  // even steps positive
          cnt    <= cnt + 1'b1;
        end
      end
    end
  end

  // the amplifier is enabled exactly while the burst runs
  assign burst_active = active;
  assign speaker_on   = active;

  // speaker must be silent whenever the amplifier is off
  a_amp_quiet : assert property (
    @(posedge clk_in) disable iff (rst_in)
    !speaker_on |-> (amp == '0)
  );

endmodule

`default_nettype wire

/* hdl/window_energy.sv */
`timescale 1ns/1ps
`default_nettype none

module window_energy (
  input  wire              clk_in,
  input  wire              rst_in,
  input  wire              step,
  input  wire              listen_start,
  input  wire signed [7:0] mic,
  output logic             onset
);

  logic [sonar_pkg::WIN_CNT_W-1:0] win_cnt;    // samples taken in the current window
  logic [sonar_pkg::SUM_W-1:0]     sum;        // running sum of the current window
  logic [sonar_pkg::SUM_W-1:0]     prev;       // last finished window
  logic [sonar_pkg::SUM_W-1:0]     prev_prev;  // the one before
  logic [7:0]                      mag;
  logic [sonar_pkg::SUM_W-1:0]     sum_next;
  logic [sonar_pkg::SUM_W:0]       thresh;     // one extra bit, prev_prev may be all ones
  logic                            win_end;
  logic                            hit;

  // -128 maps to 128, which still fits unsigned in 8 bits
  assign mag      = mic[7] ? -mic : mic;
  assign sum_next = sum + {{(sonar_pkg::SUM_W - 8){1'b0}}, mag};

  // 1.5 times the window before the previous one
  assign thresh = {1'b0, prev_prev} + {2'b00, prev_prev[sonar_pkg::SUM_W-1:1]};

  assign win_end = step && (win_cnt == sonar_pkg::WIN_LAST);
  assign hit     = (sum_next > prev) && ({1'b0, sum_next} > thresh);
  assign onset   = win_end && hit;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      win_cnt   <= '0;
      sum       <= '0;
      prev      <= '1;
      prev_prev <= '1;
    end else if (listen_start) begin
      // all-ones history keeps the first two windows from firing
      win_cnt   <= '0;
      sum       <= '0;
      prev      <= '1;
      prev_prev <= '1;
    end else if (step) begin
      if (win_end) begin
        win_cnt <= '0;
        sum     <= '0;
        if (!hit) begin
          prev      <= sum_next;
          prev_prev <= prev;
        end
      end else begin
        win_cnt <= win_cnt + 1'b1;
        sum     <= sum_next;
      end
    end
  end

  // onset is tied to the sample that closes a window
  a_onset_on_step : assert property (
    @(posedge clk_in) disable iff (rst_in)
    onset |-> step
  );

endmodule

`default_nettype wire

/* hdl/range_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module range_controller (
  input  wire                              clk_in,
  input  wire                              rst_in,
  input  wire                              step,
  input  wire                              meas_req,
  output logic                             meas_ack,
  output logic                             result_req,
  input  wire                              result_ack,
  output logic                             burst_start,
  input  wire                              burst_active,
  output logic                             listen_start,
  input  wire                              onset,
  output logic [sonar_pkg::DELAY_W-1:0]    delay,
  output logic                             timeout
);

  sonar_pkg::range_state_t          state;
  logic                             burst_seen;    // burst_active has been high this measurement
  logic [sonar_pkg::DELAY_W-1:0]    step_cnt;      // analysed steps since burst end
  logic [sonar_pkg::DELAY_W-1:0]    step_cnt_inc;
  logic                             ack_hold;      // meas_ack stays high after this clock

  assign step_cnt_inc = step_cnt + 1'b1;
  assign ack_hold     = meas_ack && meas_req;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state        <= sonar_pkg::IDLE;
      meas_ack     <= 1'b0;
      result_req   <= 1'b0;
      burst_start  <= 1'b0;
      listen_start <= 1'b0;
      burst_seen   <= 1'b0;
      step_cnt     <= '0;
      delay        <= '0;
      timeout      <= 1'b0;
    end else begin
      burst_start  <= 1'b0;  // single-cycle pulses
      listen_start <= 1'b0;

      // host dropped its request, finish the measurement handshake
      if (meas_ack && !meas_req) begin
        meas_ack <= 1'b0;
      end

      case (state)
        sonar_pkg::IDLE: begin
          if (meas_req && !meas_ack) begin
            meas_ack    <= 1'b1;
            burst_start <= 1'b1;
            burst_seen  <= 1'b0;
            state       <= sonar_pkg::BURST;
          end
        end

        sonar_pkg::BURST: begin
          if (burst_active) begin
            burst_seen <= 1'b1;
          end else if (burst_seen) begin
            // burst just ended, start analysing the echo
            listen_start <= 1'b1;
            step_cnt     <= '0;
            state        <= sonar_pkg::LISTEN;
          end
        end

        sonar_pkg::LISTEN: begin
          if (step) begin
            if (onset) begin
              delay      <= step_cnt_inc;
              timeout    <= 1'b0;
              result_req <= !ack_hold;
              state      <= sonar_pkg::REPORT;
            end else if (step_cnt_inc == sonar_pkg::DELAY_MAX) begin
              delay      <= sonar_pkg::DELAY_MAX;  // nothing heard in range
              timeout    <= 1'b1;
              result_req <= !ack_hold;
              state      <= sonar_pkg::REPORT;
            end else begin
              step_cnt <= step_cnt_inc;
            end
          end
        end

        sonar_pkg::REPORT: begin
          if (!result_req) begin
            result_req <= !ack_hold;  // held back until meas_ack is low
          end else if (result_ack) begin
            result_req <= 1'b0;
            state      <= sonar_pkg::RELEASE;
          end
        end

        sonar_pkg::RELEASE: begin
          if (!result_ack) begin
            state <= sonar_pkg::IDLE;
          end
        end

        default: begin
          state <= sonar_pkg::IDLE;
        end
      endcase
    end
  end

  // the two handshakes never overlap
  a_req_after_ack : assert property (
    @(posedge clk_in) disable iff (rst_in)
    $rose(result_req) |-> !meas_ack
  );

  // result data holds for the whole result handshake
  a_delay_stable : assert property (
    @(posedge clk_in) disable iff (rst_in)
    ($past(result_req) && result_req) |-> ($stable(delay) && $stable(timeout))
  );

endmodule

`default_nettype wire

/* hdl/sos_ranging_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sos_ranging_top (
  input  wire                                     clk_in,
  input  wire                                     rst_in,
  input  wire                                     step,        // sample strobe from the codec
  input  wire signed [7:0]                        mic,
  input  wire                                     meas_req,
  output logic                                    meas_ack,
  output logic                                    result_req,
  input  wire                                     result_ack,
  output logic [sonar_pkg::DELAY_W-1:0]           delay,
  output logic                                    timeout,
  output logic signed [sonar_pkg::AMP_W-1:0]      amp,
  output logic                                    speaker_on
);

  logic burst_start;
  logic burst_active;
  logic listen_start;
  logic onset;

  range_controller i_range_controller (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .step         (step),
    .meas_req     (meas_req),
    .meas_ack     (meas_ack),
    .result_req   (result_req),
    .result_ack   (result_ack),
    .burst_start  (burst_start),
    .burst_active (burst_active),
    .listen_start (listen_start),
    .onset        (onset),
    .delay        (delay),
    .timeout      (timeout)
  );

  impulse_generator i_impulse_generator (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .step         (step),
    .burst_start  (burst_start),
    .burst_active (burst_active),
    .speaker_on   (speaker_on),
    .amp          (amp)
  );

  // free-running detector, the controller only listens to it in LISTEN
  window_energy i_window_energy (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .step         (step),
    .listen_start (listen_start),
    .mic          (mic),
    .onset        (onset)
  );

endmodule

`default_nettype wire

/* tb/tb_sos_ranging.sv */
`timescale 1ns/1ps

module tb_sos_ranging;

  localparam int STEP_DIV = 4;  // clocks per sample step
  localparam int ACK_TIMEOUT = 20;
  localparam int BURST_TIMEOUT = 64;
  localparam int RESULT_TIMEOUT = (sonar_pkg::MAX_DELAY + 8) * STEP_DIV + 64;
  localparam int STIM_DEPTH = 512;
  localparam string STIM_FILE = "tb/sos_stim.txt";

  logic                                clk_in = 1'b0;
  logic                                rst_in;
  logic                                step = 1'b0;
  logic signed [7:0]                   mic = '0;
  logic                                meas_req;
  logic                                meas_ack;
  logic                                result_req;
  logic                                result_ack;
  logic [sonar_pkg::DELAY_W-1:0]       delay;
  logic                                timeout;
  logic signed [sonar_pkg::AMP_W-1:0]  amp;
  logic                                speaker_on;

  logic [15:0] stim_mem [0:STIM_DEPTH-1];
  int          cur_base;             // first sample of the running block
  int          cur_count;
  logic        feeding = 1'b0;       // file samples go out on steps
  int          feed_idx = 0;
  int          div_cnt = 0;
  integer      seed = 28;
  int          err_total;
  int          pass_cnt;
  int          fail_cnt;
  string       stall_what;
  event        stall_ev;

  always #20 clk_in = ~clk_in;

  // codec strobe and mic samples, one sample per step
  always @(posedge clk_in) begin
    div_cnt <= (div_cnt == STEP_DIV - 1) ? 0 : div_cnt + 1;
    if (div_cnt == STEP_DIV - 1) begin
      step <= 1'b1;
      if (feeding && feed_idx < cur_count) begin
        mic <= signed'(stim_mem[cur_base + feed_idx][7:0]);
      end else begin
        mic <= '0;  // silence once the block runs out
      end
    end else begin
      step <= 1'b0;
      mic  <= '0;
    end
    if (!feeding) begin
      feed_idx <= 0;
    end else if (div_cnt == STEP_DIV - 1) begin
      feed_idx <= feed_idx + 1;
    end
  end

  sos_ranging_top i_sos_ranging_top (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .step       (step),
    .mic        (mic),
    .meas_req   (meas_req),
    .meas_ack   (meas_ack),
    .result_req (result_req),
    .result_ack (result_ack),
    .delay      (delay),
    .timeout    (timeout),
    .amp        (amp),
    .speaker_on (speaker_on)
  );

  task automatic check_value(input string field, input int got, input int exp);
    assert (got == exp) else begin
      $display("FAIL %0d ns %s: got %0d, expected %0d", $time, field, got, exp);
      err_total++;
    end
  endtask

  // hand the stall to the watcher below and park this process
  task automatic raise_stall(input string what);
    stall_what = what;
    -> stall_ev;
    forever @(posedge clk_in);
  endtask

  initial begin
    @(stall_ev);
    $display("run stopped, %s (state %s)", stall_what,
             i_sos_ranging_top.i_range_controller.state.name());
    $display("Test FAILED");
    $finish;
  end

  task automatic request_measurement();
    int cnt;
    @(posedge clk_in);
    meas_req <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk_in);
      cnt++;
      if (cnt > ACK_TIMEOUT) raise_stall("meas_ack never rose after meas_req");
    end while (!meas_ack);
    check_value("meas_ack rise latency", cnt, 2);  // seen high one clock after the raise
    @(posedge clk_in);
    meas_req <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk_in);
      cnt++;
      if (cnt > ACK_TIMEOUT) raise_stall("meas_ack stayed high after meas_req fell");
    end while (meas_ack);
    check_value("meas_ack fall latency", cnt, 2);  // seen low one clock after the drop
  endtask

  task automatic check_burst();
    int cnt;
    int exp_amp;
    cnt = 0;
    while (!speaker_on) begin
      check_value("amp before burst", int'(amp), 0);
      @(negedge clk_in);
      cnt++;
      if (cnt > BURST_TIMEOUT) raise_stall("speaker_on never rose after the request");
    end
    cnt = 0;
    while (speaker_on) begin
      // sign flips every step, first step positive
      exp_amp = ((cnt / STEP_DIV) % 2 == 0) ? sonar_pkg::BURST_AMP : -sonar_pkg::BURST_AMP;
      check_value("amp in burst", int'(amp), exp_amp);
      @(negedge clk_in);
      cnt++;
      if (cnt > BURST_TIMEOUT) raise_stall("speaker_on stuck high");
    end
    feeding = 1'b1;
    check_value("burst length in clocks", cnt, sonar_pkg::BURST_STEPS * STEP_DIV);
    check_value("amp after burst", int'(amp), 0);
  endtask

  task automatic collect_result(input int exp_delay, input int exp_timeout);
    int cnt;
    int hold;
    cnt = 0;
    while (!result_req) begin
      @(negedge clk_in);
      cnt++;
      if (cnt > RESULT_TIMEOUT) raise_stall("result_req never rose");
    end
    feeding = 1'b0;
    check_value("meas_ack during result", int'(meas_ack), 0);
    check_value("delay", int'(delay), exp_delay);
    check_value("timeout", int'(timeout), exp_timeout);
    hold = $random(seed) & 7;  // host back-pressure, 0 to 7 clocks
    repeat (hold) begin
      @(negedge clk_in);
      check_value("result_req before result_ack", int'(result_req), 1);
      check_value("delay while held", int'(delay), exp_delay);
    end
    @(posedge clk_in);
    result_ack <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk_in);
      cnt++;
      if (cnt > ACK_TIMEOUT) raise_stall("result_req stayed high after result_ack");
    end while (result_req);
    @(posedge clk_in);
    result_ack <= 1'b0;
    repeat (2) @(negedge clk_in);  // RELEASE back to IDLE
  endtask

  task automatic run_test(input int num, input int base, input int count,
                          input int exp_delay, input int exp_timeout);
    int errs_before;
    errs_before = err_total;
    cur_base  = base;
    cur_count = count;
    @(negedge clk_in);
    fork
      request_measurement();
      check_burst();
    join
    collect_result(exp_delay, exp_timeout);
    if (err_total == errs_before) begin
      pass_cnt++;
      $display("test %0d passed: delay %0d timeout %0d", num, exp_delay, exp_timeout);
    end else begin
      fail_cnt++;
      $display("test %0d failed with %0d errors", num, err_total - errs_before);
    end
  endtask

  initial begin
    int i;
    int pos;
    int count;
    int num;
    rst_in     = 1'b1;
    meas_req   = 1'b0;
    result_ack = 1'b0;
    err_total  = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    for (i = 0; i < STIM_DEPTH; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh(STIM_FILE, stim_mem);

    repeat (4) @(posedge clk_in);
    rst_in <= 1'b0;
    @(negedge clk_in);
    check_value("meas_ack after reset", int'(meas_ack), 0);
    check_value("result_req after reset", int'(result_req), 0);
    check_value("speaker_on after reset", int'(speaker_on), 0);
    check_value("amp after reset", int'(amp), 0);

    // blocks: count, delay, timeout, then count samples; count 0 ends the file
    pos = 0;
    num = 0;
    while (pos < STIM_DEPTH - 3 && stim_mem[pos] != 16'h0) begin
      count = int'(stim_mem[pos]);
      num++;
      run_test(num, pos + 3, count, int'(stim_mem[pos + 1]), int'(stim_mem[pos + 2]));
      pos += 3 + count;
    end
    if (num == 0) begin
      $display("no test blocks found in %s", STIM_FILE);
      err_total++;
    end

    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (err_total == 0 && fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* tb/sos_stim.txt */
// each block: sample count, expected delay, expected timeout (hex words)
// then that many mic samples, 8-bit two's complement, one window per line
18 18 0   // echo in window 3, delay 24
01 ff 02 fe 01 ff 01 ff
01 ff 02 fe 01 ff 01 ff
50 b0 50 b0 50 b0 50 b0
28 28 0   // echo starts inside window 5, delay 40
01 ff 02 fe 01 ff 01 ff
01 ff 02 fe 01 ff 01 ff
01 ff 02 fe 01 ff 01 ff
01 ff 02 fe 01 ff 01 ff
02 fe 01 ff 60 a0 60 a0
28 28 0   // sums 10 12 14 17 30, only window 5 beats 1.5x, delay 40
01 ff 02 fe 01 ff 01 ff
02 fe 02 fe 01 ff 01 ff
02 fe 02 fe 02 fe 01 ff
03 fe 02 fe 02 fe 02 fe
04 fc 04 fc 04 fc 03 fd
08 ff 1   // one quiet window then silence, timeout
01 ff 02 fe 01 ff 01 ff
20 ff 1   // decaying ringing 40 30 20 10, timeout
05 fb 05 fb 05 fb 05 fb
04 fc 04 fc 04 fc 03 fd
03 fd 03 fd 02 fe 02 fe
01 ff 02 fe 01 ff 01 ff
20 20 0   // full-scale echo late in window 4, delay 32
01 ff 02 fe 01 ff 01 ff
01 ff 02 fe 01 ff 01 ff
01 ff 02 fe 01 ff 01 ff
01 ff 01 ff 01 ff 80 80
18 18 0   // window 3 echo again right after a timeout
01 ff 02 fe 01 ff 01 ff
01 ff 02 fe 01 ff 01 ff
50 b0 50 b0 50 b0 50 b0
0         // end of tests

/* tb.f */
hdl/sonar_pkg.sv
hdl/impulse_generator.sv
hdl/window_energy.sv
hdl/range_controller.sv
hdl/sos_ranging_top.sv
tb/tb_sos_ranging.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sos_ranging -f tb.f

out=$(./obj_dir/Vtb_sos_ranging) || true
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
